//--- design/failover_pkg.sv
`default_nettype none

package failover_pkg;

	// 0 = 10M, 1 = 100M, 2 = 1000M
	typedef logic [1:0] speed_t;

	typedef logic [15:0] delay_t;   // Link-up qualification cycles
	typedef logic [7:0]  err_cnt_t; // Consecutive rx errors

	typedef struct packed {
		logic   up;
		speed_t speed;
		logic   duplex;
	} link_status_t;

	typedef struct packed {
		logic [7:0] data;
		logic       dv;
		logic       er;
		logic       crs;
		logic       col;
	} gmii_rx_t;

	typedef struct packed {
		logic [7:0] data;
		logic       en;
		logic       er;
	} gmii_tx_t;

	// Byte addresses of the register block
	localparam logic [3:0] REG_UP_DELAY   = 4'h0;
	localparam logic [3:0] REG_ERR_THRESH = 4'h4;
	localparam logic [3:0] REG_STATUS     = 4'h8;
	localparam logic [3:0] REG_FAILOVERS  = 4'hC;

endpackage

`default_nettype wire

//--- design/link_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module link_monitor import failover_pkg::*; (
	input  wire          clk,
	input  wire          reset,
	input  wire link_status_t phy_status_i,
	input  wire delay_t   up_delay_i,
	output link_status_t qual_status_o
);

	link_status_t sync_q1;
	link_status_t sync_q2;
	delay_t       stable_cnt;

	// In-band status comes from the PHY clock domain
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= phy_status_i;
			sync_q2 <= sync_q1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stable_cnt    <= '0;
			qual_status_o <= '0;
		end else begin
			qual_status_o.speed  <= sync_q2.speed;
			qual_status_o.duplex <= sync_q2.duplex;
			if (!sync_q2.up) begin
				// Any drop restarts qualification
				stable_cnt       <= '0;
				qual_status_o.up <= 1'b0;
			end else if (stable_cnt + 1'b1 >= up_delay_i) begin
				qual_status_o.up <= 1'b1; // Current up cycle counts too
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

	// Delay lowered below a running count still qualifies at once
	// since the compare is not an equality

endmodule

`default_nettype wire

//--- design/port_selector.sv
`timescale 1ns/10ps
`default_nettype none

module port_selector import failover_pkg::*; (
	input  wire          clk,
	input  wire          reset,
	input  wire link_status_t phy0_i,
	input  wire link_status_t phy1_i,
	input  wire          mac_rx_err_i,
	input  wire          mac_rx_ok_i,
	input  wire err_cnt_t err_thresh_i,
	output link_status_t link_o,
	output logic         active_port_o,
	output logic         link_change_o,
	output logic         failover_o
);

	typedef enum logic [1:0] {
		LINK_DOWN,
		ON_PHY0,
		ON_PHY1
	} sel_state_t;

	sel_state_t   state;
	sel_state_t   state_nxt;
	err_cnt_t     err_cnt;
	link_status_t link_nxt;
	logic         port_nxt;

	always_comb begin
		state_nxt = state;
		if (!phy0_i.up && !phy1_i.up)
			state_nxt = LINK_DOWN;
		else if (state == LINK_DOWN)
			state_nxt = phy0_i.up ? ON_PHY0 : ON_PHY1;
		else if (state == ON_PHY1 && phy0_i.up)
			state_nxt = ON_PHY0; // Port 0 preferred
		else if (state == ON_PHY0 && !phy0_i.up)
			state_nxt = ON_PHY1;
		else if (state == ON_PHY0 && phy1_i.up && err_cnt >= err_thresh_i)
			state_nxt = ON_PHY1; // On PHY 1 the standby is down here
	end

	// Speed and duplex follow the active PHY
	always_comb begin
		case (state_nxt)
			ON_PHY0: link_nxt = phy0_i;
			ON_PHY1: link_nxt = phy1_i;
			default: link_nxt = '0;
		endcase
	end

	assign port_nxt = (state_nxt == ON_PHY1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state         <= LINK_DOWN;
			link_o        <= '0;
			active_port_o <= 1'b0;
			link_change_o <= 1'b0;
			failover_o    <= 1'b0;
			err_cnt       <= '0;
		end else begin
			state         <= state_nxt;
			link_o        <= link_nxt;
			active_port_o <= port_nxt;
			link_change_o <= (link_nxt != link_o) || (port_nxt != active_port_o);
			failover_o    <= (state != LINK_DOWN) && (state_nxt != LINK_DOWN) &&
				(state_nxt != state);
			if (state_nxt != state)
				err_cnt <= '0;
			else if (mac_rx_ok_i)
				err_cnt <= '0;
			else if (mac_rx_err_i && err_cnt != '1)
				err_cnt <= err_cnt + 1'b1; // Saturates
		end
	end

	a_down_clears_link: assert property (@(posedge clk) disable iff (reset)
		(!phy0_i.up && !phy1_i.up) ##1 (!phy0_i.up && !phy1_i.up) |-> !link_o.up);

endmodule

`default_nettype wire

//--- design/gmii_port_mux.sv
`timescale 1ns/10ps
`default_nettype none

module gmii_port_mux import failover_pkg::*; (
	input  wire      clk,
	input  wire      reset,
	input  wire      active_port_i,
	input  wire gmii_rx_t phy0_rx_i,
	input  wire gmii_rx_t phy1_rx_i,
	input  wire gmii_tx_t mac_tx_i,
	output gmii_rx_t mac_rx_o,
	output gmii_tx_t phy0_tx_o,
	output gmii_tx_t phy1_tx_o
);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mac_rx_o <= '0;
		end else begin
			mac_rx_o <= active_port_i ? phy1_rx_i : phy0_rx_i;
		end
	end

	// Standby PHY sees an idle line
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phy0_tx_o <= '0;
			phy1_tx_o <= '0;
		end else if (active_port_i) begin
			phy0_tx_o <= '0;
			phy1_tx_o <= mac_tx_i;
		end else begin
			phy0_tx_o <= mac_tx_i;
			phy1_tx_o <= '0;
		end
	end

endmodule

`default_nettype wire

//--- design/failover_regs.sv
`timescale 1ns/10ps
`default_nettype none

module failover_regs import failover_pkg::*; #(
	parameter delay_t   DEFAULT_UP_DELAY   = 16'd1000,
	parameter err_cnt_t DEFAULT_ERR_THRESH = 8'd8
) (
	input  wire          clk,
	input  wire          reset,
	input  wire  [3:0]   awaddr_i,
	input  wire          awvalid_i,
	output logic         awready_o,
	input  wire  [31:0]  wdata_i,
	input  wire  [3:0]   wstrb_i,
	input  wire          wvalid_i,
	output logic         wready_o,
	output logic [1:0]   bresp_o,
	output logic         bvalid_o,
	input  wire          bready_i,
	input  wire  [3:0]   araddr_i,
	input  wire          arvalid_i,
	output logic         arready_o,
	output logic [31:0]  rdata_o,
	output logic [1:0]   rresp_o,
	output logic         rvalid_o,
	input  wire          rready_i,
	input  wire link_status_t link_i,
	input  wire          active_port_i,
	input  wire          phy0_up_i,
	input  wire          phy1_up_i,
	input  wire          failover_i,
	output delay_t       up_delay_o,
	output err_cnt_t     err_thresh_o
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic        wr_accept;
	logic        wr_mapped;
	logic        rd_accept;
	logic        rd_err;
	logic [31:0] rd_word;
	logic [31:0] status_word;
	logic [15:0] failover_cnt;

	assign wr_accept = awvalid_i && wvalid_i && !bvalid_o;
	assign awready_o = wr_accept;
	assign wready_o  = wr_accept;
	assign arready_o = !rvalid_o;
	assign rd_accept = arvalid_i && !rvalid_o;

	// STATUS is read-only
	assign wr_mapped = (awaddr_i == REG_UP_DELAY) || (awaddr_i == REG_ERR_THRESH) ||
		(awaddr_i == REG_FAILOVERS);

	assign status_word = {25'd0, phy1_up_i, phy0_up_i, active_port_i, link_i};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			up_delay_o   <= DEFAULT_UP_DELAY;
			err_thresh_o <= DEFAULT_ERR_THRESH;
		end else if (wr_accept) begin
			case (awaddr_i)
				REG_UP_DELAY: begin
					if (wstrb_i[0])
						up_delay_o[7:0] <= wdata_i[7:0];
					if (wstrb_i[1])
						up_delay_o[15:8] <= wdata_i[15:8];
				end
				REG_ERR_THRESH: begin
					if (wstrb_i[0])
						err_thresh_o <= wdata_i[7:0];
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			failover_cnt <= '0;
		else if (wr_accept && awaddr_i == REG_FAILOVERS)
			failover_cnt <= '0; // Clear wins over a pulse
		else if (failover_i && failover_cnt != '1)
			failover_cnt <= failover_cnt + 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			bvalid_o <= 1'b0;
			bresp_o  <= RESP_OKAY;
		end else if (wr_accept) begin
			bvalid_o <= 1'b1;
			bresp_o  <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
		end else if (bready_i) begin
			bvalid_o <= 1'b0;
		end
	end

	always_comb begin
		rd_err = 1'b0;
		case (araddr_i)
			REG_UP_DELAY:   rd_word = {16'd0, up_delay_o};
			REG_ERR_THRESH: rd_word = {24'd0, err_thresh_o};
			REG_STATUS:     rd_word = status_word;
			REG_FAILOVERS:  rd_word = {16'd0, failover_cnt};
			default: begin
				rd_word = '0;
				rd_err  = 1'b1; // Unaligned
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rvalid_o <= 1'b0;
			rdata_o  <= '0;
			rresp_o  <= RESP_OKAY;
		end else if (rd_accept) begin
			rvalid_o <= 1'b1;
			rdata_o  <= rd_word;
			rresp_o  <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end else if (rready_i) begin
			rvalid_o <= 1'b0;
		end
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

endmodule

`default_nettype wire

//--- design/phy_failover_top.sv
`timescale 1ns/10ps
`default_nettype none

module phy_failover_top import failover_pkg::*; #(
	parameter delay_t   DEFAULT_UP_DELAY   = 16'd1000,
	parameter err_cnt_t DEFAULT_ERR_THRESH = 8'd8
) (
	input  wire               clk,
	input  wire               reset,
	input  wire link_status_t phy0_status_i,
	input  wire link_status_t phy1_status_i,
	input  wire gmii_rx_t     phy0_rx_i,
	input  wire gmii_rx_t     phy1_rx_i,
	input  wire gmii_tx_t     mac_tx_i,
	input  wire               mac_rx_err_i,
	input  wire               mac_rx_ok_i,
	input  wire  [3:0]        awaddr_i,
	input  wire               awvalid_i,
	output wire               awready_o,
	input  wire  [31:0]       wdata_i,
	input  wire  [3:0]        wstrb_i,
	input  wire               wvalid_i,
	output wire               wready_o,
	output wire  [1:0]        bresp_o,
	output wire               bvalid_o,
	input  wire               bready_i,
	input  wire  [3:0]        araddr_i,
	input  wire               arvalid_i,
	output wire               arready_o,
	output wire  [31:0]       rdata_o,
	output wire  [1:0]        rresp_o,
	output wire               rvalid_o,
	input  wire               rready_i,
	output wire gmii_rx_t     mac_rx_o,
	output wire gmii_tx_t     phy0_tx_o,
	output wire gmii_tx_t     phy1_tx_o,
	output wire link_status_t link_o,
	output wire               active_port_o,
	output wire               link_change_o
);

	link_status_t qual0;
	link_status_t qual1;
	delay_t       up_delay;
	err_cnt_t     err_thresh;
	logic         failover;

	link_monitor link_monitor0_i (
		.clk(clk), .reset(reset),
		.phy_status_i(phy0_status_i), .up_delay_i(up_delay),
		.qual_status_o(qual0)
	);

	link_monitor link_monitor1_i (
		.clk(clk), .reset(reset),
		.phy_status_i(phy1_status_i), .up_delay_i(up_delay),
		.qual_status_o(qual1)
	);

	port_selector port_selector_i (
		.clk(clk), .reset(reset),
		.phy0_i(qual0), .phy1_i(qual1),
		.mac_rx_err_i(mac_rx_err_i), .mac_rx_ok_i(mac_rx_ok_i),
		.err_thresh_i(err_thresh),
		.link_o(link_o), .active_port_o(active_port_o),
		.link_change_o(link_change_o), .failover_o(failover)
	);

	gmii_port_mux gmii_port_mux_i (
		.clk(clk), .reset(reset),
		.active_port_i(active_port_o),
		.phy0_rx_i(phy0_rx_i), .phy1_rx_i(phy1_rx_i), .mac_tx_i(mac_tx_i),
		.mac_rx_o(mac_rx_o), .phy0_tx_o(phy0_tx_o), .phy1_tx_o(phy1_tx_o)
	);

	failover_regs #(
		.DEFAULT_UP_DELAY(DEFAULT_UP_DELAY),
		.DEFAULT_ERR_THRESH(DEFAULT_ERR_THRESH)
	) failover_regs_i (
		.clk(clk), .reset(reset),
		.awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
		.wdata_i(wdata_i), .wstrb_i(wstrb_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
		.bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
		.araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
		.rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o), .rready_i(rready_i),
		.link_i(link_o), .active_port_i(active_port_o),
		.phy0_up_i(qual0.up), .phy1_up_i(qual1.up), // Qualified, not raw
		.failover_i(failover),
		.up_delay_o(up_delay), .err_thresh_o(err_thresh)
	);

endmodule

`default_nettype wire

//--- verif/failover_checker.sv
`timescale 1ns/10ps
`default_nettype none

module failover_checker import failover_pkg::*; #(
	parameter delay_t   DEFAULT_UP_DELAY   = 16'd1000,
	parameter err_cnt_t DEFAULT_ERR_THRESH = 8'd8
) (
	input  wire               clk,
	input  wire               reset,
	input  wire link_status_t phy0_status_i,
	input  wire link_status_t phy1_status_i,
	input  wire gmii_rx_t     phy0_rx_i,
	input  wire gmii_rx_t     phy1_rx_i,
	input  wire gmii_tx_t     mac_tx_i,
	input  wire               mac_rx_err_i,
	input  wire               mac_rx_ok_i,
	input  wire  [3:0]        awaddr_i,
	input  wire  [31:0]       wdata_i,
	input  wire               awvalid_i,
	input  wire               wvalid_i,
	input  wire               awready_i,
	input  wire               wready_i,
	input  wire               bready_i,
	input  wire               bvalid_i,
	input  wire  [1:0]        bresp_i,
	input  wire  [3:0]        araddr_i,
	input  wire               arvalid_i,
	input  wire               arready_i,
	input  wire               rready_i,
	input  wire               rvalid_i,
	input  wire  [31:0]       rdata_i,
	input  wire  [1:0]        rresp_i,
	input  wire link_status_t link_i,
	input  wire               active_port_i,
	input  wire               link_change_i,
	input  wire gmii_rx_t     mac_rx_i,
	input  wire gmii_tx_t     phy0_tx_i,
	input  wire gmii_tx_t     phy1_tx_i,
	output int                errors_o
);

	localparam logic [1:0] DOWN = 2'd0;
	localparam logic [1:0] P0   = 2'd1;
	localparam logic [1:0] P1   = 2'd2;

	link_status_t s1 [2];
	link_status_t s2 [2];
	link_status_t q [2];
	delay_t       cnt [2];
	link_status_t link;
	link_status_t link_n;
	logic [1:0]   st;
	logic [1:0]   st_n;
	logic         port;
	logic         port_n;
	logic         change;
	logic         fo;
	err_cnt_t     errc;
	err_cnt_t     thr;
	delay_t       dly;
	logic [15:0]  fcount;
	gmii_rx_t     exp_rx;
	gmii_tx_t     exp_tx0;
	gmii_tx_t     exp_tx1;
	logic         bv;
	logic         rv;
	logic         acc;
	logic [1:0]   br;
	logic [1:0]   rr;
	logic [31:0]  rd;

	initial errors_o = 0;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors_o++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int p = 0; p < 2; p++) begin
				s1[p] = '0;
				s2[p] = '0;
				q[p] = '0;
				cnt[p] = '0;
			end
			st = DOWN;
			link = '0;
			port = 1'b0;
			change = 1'b0;
			fo = 1'b0;
			errc = '0;
			thr = DEFAULT_ERR_THRESH;
			dly = DEFAULT_UP_DELAY;
			fcount = '0;
			exp_rx = '0;
			exp_tx0 = '0;
			exp_tx1 = '0;
			bv = 1'b0;
			rv = 1'b0;
			br = 2'b00;
			rr = 2'b00;
			rd = '0;
		end else begin
			acc = awvalid_i && wvalid_i && !bv;
			compare("link_o", link_i, link);
			compare("active_port_o", active_port_i, port);
			compare("link_change_o", link_change_i, change);
			compare("mac_rx_o", mac_rx_i, exp_rx);
			compare("phy0_tx_o", phy0_tx_i, exp_tx0);
			compare("phy1_tx_o", phy1_tx_i, exp_tx1);
			compare("awready_o", awready_i, acc);
			compare("wready_o", wready_i, acc);
			compare("arready_o", arready_i, !rv);
			compare("bvalid_o", bvalid_i, bv);
			compare("rvalid_o", rvalid_i, rv);
			if (bv)
				compare("bresp_o", bresp_i, br);
			if (rv) begin
				compare("rdata_o", rdata_i, rd);
				compare("rresp_o", rresp_i, rr);
			end

			// Register reads see this cycle's status
			if (arvalid_i && !rv) begin
				rv = 1'b1;
				rr = 2'b00;
				case (araddr_i)
					REG_UP_DELAY:   rd = {16'd0, dly};
					REG_ERR_THRESH: rd = {24'd0, thr};
					REG_STATUS:     rd = {25'd0, q[1].up, q[0].up, port, link};
					REG_FAILOVERS:  rd = {16'd0, fcount};
					default: begin
						rd = '0;
						rr = 2'b10;
					end
				endcase
			end else if (rready_i) begin
				rv = 1'b0;
			end

			if (acc) begin
				bv = 1'b1;
				br = (awaddr_i == REG_UP_DELAY || awaddr_i == REG_ERR_THRESH ||
					awaddr_i == REG_FAILOVERS) ? 2'b00 : 2'b10;
			end else if (bready_i) begin
				bv = 1'b0;
			end
			if (acc && awaddr_i == REG_FAILOVERS)
				fcount = '0;
			else if (fo && fcount != 16'hFFFF)
				fcount = fcount + 1'b1;

			exp_rx = port ? phy1_rx_i : phy0_rx_i;
			exp_tx0 = port ? gmii_tx_t'('0) : mac_tx_i;
			exp_tx1 = port ? mac_tx_i : gmii_tx_t'('0);

			// Selector rules in priority order
			st_n = st;
			if (!q[0].up && !q[1].up)
				st_n = DOWN;
			else if (st == DOWN)
				st_n = q[0].up ? P0 : P1;
			else if (st == P1 && q[0].up)
				st_n = P0;
			else if (st == P0 && !q[0].up)
				st_n = P1;
			else if (errc >= thr && q[(st == P0) ? 1 : 0].up)
				st_n = (st == P0) ? P1 : P0;
			link_n = (st_n == P0) ? q[0] : (st_n == P1) ? q[1] : link_status_t'('0);
			port_n = (st_n == P1);
			change = (link_n != link) || (port_n != port);
			fo = (st != DOWN) && (st_n != DOWN) && (st_n != st);
			if (st_n != st || mac_rx_ok_i)
				errc = '0;
			else if (mac_rx_err_i && errc != 8'hFF)
				errc = errc + 1'b1;
			st = st_n;
			link = link_n;
			port = port_n;

			for (int p = 0; p < 2; p++) begin
				q[p].speed = s2[p].speed;
				q[p].duplex = s2[p].duplex;
				if (!s2[p].up) begin
					cnt[p] = '0;
					q[p].up = 1'b0;
				end else begin
					if (cnt[p] != 16'hFFFF)
						cnt[p] = cnt[p] + 1'b1; // Synced up cycles, this one included
					if (cnt[p] >= dly)
						q[p].up = 1'b1;
				end
				s2[p] = s1[p];
			end
			s1[0] = phy0_status_i;
			s1[1] = phy1_status_i;

			if (acc && awaddr_i == REG_UP_DELAY)
				dly = wdata_i[15:0];
			if (acc && awaddr_i == REG_ERR_THRESH)
				thr = wdata_i[7:0];
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_phy_failover.sv
`timescale 1ns/10ps
`default_nettype none

module tb_phy_failover import failover_pkg::*; ();

	localparam int       PERIOD       = 40;
	localparam int       RESET_CYCLES = 10;
	localparam int       STIM_CYCLES  = 6000;
	localparam int       CYCLE_LIMIT  = RESET_CYCLES + STIM_CYCLES + 200;
	localparam delay_t   UP_DELAY     = 16'd20;
	localparam err_cnt_t ERR_THRESH   = 8'd4;

	logic         clk;
	logic         reset;
	link_status_t phy0_status;
	link_status_t phy1_status;
	link_status_t link;
	gmii_rx_t     phy0_rx;
	gmii_rx_t     phy1_rx;
	gmii_rx_t     mac_rx;
	gmii_tx_t     mac_tx;
	gmii_tx_t     phy0_tx;
	gmii_tx_t     phy1_tx;
	logic         rx_err;
	logic         rx_ok;
	logic         active_port;
	logic         link_change;
	logic [3:0]   awaddr;
	logic [3:0]   araddr;
	logic [3:0]   wstrb;
	logic [31:0]  wdata;
	logic [31:0]  rdata;
	logic         awvalid;
	logic         wvalid;
	logic         bready;
	logic         arvalid;
	logic         rready;
	logic         awready;
	logic         wready;
	logic         bvalid;
	logic         arready;
	logic         rvalid;
	logic [1:0]   bresp;
	logic [1:0]   rresp;
	logic [31:0]  lcg_state = 32'd36459;
	logic         wr_taken;
	logic         rd_taken;
	int           hold [2];
	int           cycles;
	int           errors;

	phy_failover_top #(
		.DEFAULT_UP_DELAY(UP_DELAY),
		.DEFAULT_ERR_THRESH(ERR_THRESH)
	) phy_failover_top_i (
		.clk(clk), .reset(reset),
		.phy0_status_i(phy0_status), .phy1_status_i(phy1_status),
		.phy0_rx_i(phy0_rx), .phy1_rx_i(phy1_rx), .mac_tx_i(mac_tx),
		.mac_rx_err_i(rx_err), .mac_rx_ok_i(rx_ok),
		.awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
		.wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
		.bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
		.araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
		.rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready),
		.mac_rx_o(mac_rx), .phy0_tx_o(phy0_tx), .phy1_tx_o(phy1_tx),
		.link_o(link), .active_port_o(active_port), .link_change_o(link_change)
	);

	failover_checker #(
		.DEFAULT_UP_DELAY(UP_DELAY),
		.DEFAULT_ERR_THRESH(ERR_THRESH)
	) failover_checker_i (
		.clk(clk), .reset(reset),
		.phy0_status_i(phy0_status), .phy1_status_i(phy1_status),
		.phy0_rx_i(phy0_rx), .phy1_rx_i(phy1_rx), .mac_tx_i(mac_tx),
		.mac_rx_err_i(rx_err), .mac_rx_ok_i(rx_ok),
		.awaddr_i(awaddr), .wdata_i(wdata), .awvalid_i(awvalid), .wvalid_i(wvalid),
		.awready_i(awready), .wready_i(wready), .bready_i(bready),
		.bvalid_i(bvalid), .bresp_i(bresp),
		.araddr_i(araddr), .arvalid_i(arvalid), .arready_i(arready),
		.rready_i(rready), .rvalid_i(rvalid), .rdata_i(rdata), .rresp_i(rresp),
		.link_i(link), .active_port_i(active_port), .link_change_i(link_change),
		.mac_rx_i(mac_rx), .phy0_tx_i(phy0_tx), .phy1_tx_i(phy1_tx),
		.errors_o(errors)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Upper bits only, the low LCG bits repeat quickly
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {8'd0, lcg_state[31:8]};
	endfunction

	// Mostly word aligned, now and then any address
	function automatic logic [3:0] pick_addr();
		logic [31:0] r;
		r = next_random();
		return (r[2:0] == 3'd0) ? r[6:3] : {r[4:3], 2'b00};
	endfunction

	task automatic drive_phys();
		logic [31:0]  r;
		link_status_t st;
		for (int p = 0; p < 2; p++) begin
			if (hold[p] == 0) begin
				r = next_random();
				hold[p] = 10 + r % 71;
				st.up = (r[9:8] != 2'b00);
				st.speed = (r[11:10] == 2'd3) ? 2'd2 : r[11:10];
				st.duplex = r[12];
				if (p == 0)
					phy0_status = st;
				else
					phy1_status = st;
			end
			hold[p]--;
		end
	endtask

	task automatic drive_gmii();
		logic [31:0] r;
		r = next_random();
		phy0_rx = r[11:0];
		phy1_rx = r[23:12];
		r = next_random();
		mac_tx = r[9:0];
		rx_err = (r[15:12] < 4'd5); // Errors outnumber good frames
		rx_ok = (r[15:12] == 4'd15);
	endtask

	task automatic drive_axi(input logic new_ops);
		logic [31:0] r;
		if (wr_taken) begin
			awvalid = 1'b0;
			wvalid = 1'b0;
		end
		if (rd_taken)
			arvalid = 1'b0;
		r = next_random();
		bready = !new_ops || (r[1:0] != 2'b00);
		rready = !new_ops || (r[3:2] != 2'b00);
		if (new_ops && !awvalid && r[8:4] == 5'd0) begin
			awaddr = pick_addr();
			wdata = next_random();
			if (awaddr == REG_UP_DELAY)
				wdata = 5 + wdata % 36;
			else if (awaddr == REG_ERR_THRESH)
				wdata = 1 + wdata % 6;
			awvalid = 1'b1;
			wvalid = 1'b1;
		end
		if (new_ops && !arvalid && r[12:9] == 4'd0) begin
			araddr = pick_addr();
			arvalid = 1'b1;
		end
	endtask

	// Handshakes are sampled at the rising edge, inputs change at the falling one
	task automatic run_cycle(input logic new_ops);
		drive_phys();
		drive_gmii();
		drive_axi(new_ops);
		@(posedge clk);
		wr_taken = awvalid && awready;
		rd_taken = arvalid && arready;
		@(negedge clk);
	endtask

	initial begin
		reset = 1'b1;
		phy0_status = '0;
		phy1_status = '0;
		phy0_rx = '0;
		phy1_rx = '0;
		mac_tx = '0;
		rx_err = 1'b0;
		rx_ok = 1'b0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = 4'hF;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		wr_taken = 1'b0;
		rd_taken = 1'b0;
		hold[0] = 0;
		hold[1] = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (STIM_CYCLES) run_cycle(1'b1);
		do begin
			run_cycle(1'b0);
		end while (awvalid || arvalid || bvalid || rvalid);
		@(posedge clk);
		@(negedge clk);
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout, run still busy after %0d cycles, %0d errors", cycles, errors);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
design/failover_pkg.sv
design/link_monitor.sv
design/port_selector.sv
design/gmii_port_mux.sv
design/failover_regs.sv
design/phy_failover_top.sv
verif/failover_checker.sv
verif/tb_phy_failover.sv

//--- Bender.yml
package:
  name: phy_failover

sources:
  - design/failover_pkg.sv
  - design/link_monitor.sv
  - design/port_selector.sv
  - design/gmii_port_mux.sv
  - design/failover_regs.sv
  - design/phy_failover_top.sv
  - target: test
    files:
      - verif/failover_checker.sv
      - verif/tb_phy_failover.sv
